// ==== hw/msi_pkg.sv ====
// MSI generator shared definitions
package msi_pkg;

  // AXI4-Lite initiator widths
  localparam int ADDR_WIDTH = 40;
  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = 8;
  localparam int RESP_WIDTH = 2;

  // Interrupt lines and destination table
  localparam int NUM_IRQ = 4;
  localparam int IRQ_IDX_WIDTH = $clog2(NUM_IRQ);
  localparam int NUM_DEST = 2;
  localparam int DEST_IDX_WIDTH = 1;

  // Message fields
  localparam int DEVICE_ID_WIDTH = 16;
  localparam int EVENT_ID_WIDTH = 16;
  localparam int THROTTLE_WIDTH = 16;

  // Configuration port
  localparam int CFG_ADDR_WIDTH = 8;
  // Register stride is 8 bytes
  localparam int REG_SHIFT = 3;

  // Field positions in REG_THROTTLE
  localparam int THR_EN_BIT = 0;
  localparam int THR_LSB = 16;

  // Field positions in REG_IRQn
  localparam int IRQ_EVENT_LSB = 0;
  localparam int IRQ_DEVICE_LSB = 16;
  localparam int IRQ_DEST_LSB = 32;
  localparam int IRQ_EN_BIT = 63;

  // Event id occupies the low four bytes of the write
  localparam logic [STRB_WIDTH-1:0] MSG_WSTRB = 8'h0f;

  typedef enum logic [RESP_WIDTH-1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } msi_resp_e;

  typedef enum logic [CFG_ADDR_WIDTH-1:0] {
    REG_THROTTLE = 8'h00,
    REG_DEST0    = 8'h08,
    REG_DEST1    = 8'h10,
    REG_IRQ0     = 8'h20,
    REG_IRQ1     = 8'h28,
    REG_IRQ2     = 8'h30,
    REG_IRQ3     = 8'h38
  } msi_reg_e;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RESP
  } msi_wr_state_e;

endpackage

// ==== hw/msi_cfg_if.sv ====
// MSI configuration bundle
interface msi_cfg_if;
  import msi_pkg::*;

  // Destination base addresses
  logic [NUM_DEST-1:0][ADDR_WIDTH-1:0] dest_addr;

  // Per-line settings
  logic [NUM_IRQ-1:0] irq_enable;
  logic [NUM_IRQ-1:0][DEST_IDX_WIDTH-1:0] dest_idx;
  logic [NUM_IRQ-1:0][DEVICE_ID_WIDTH-1:0] device_id;
  logic [NUM_IRQ-1:0][EVENT_ID_WIDTH-1:0] event_id;

  // Message spacing
  logic throttle_en;
  logic [THROTTLE_WIDTH-1:0] throttle_threshold;

  modport regs (
    output dest_addr, irq_enable, dest_idx, device_id, event_id,
    output throttle_en, throttle_threshold
  );

  modport pending (
    input irq_enable
  );

  modport writer (
    input dest_addr, dest_idx, device_id, event_id,
    input throttle_en, throttle_threshold
  );

endinterface

// ==== hw/msi_cfg_regs.sv ====
// MSI configuration registers
module msi_cfg_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                cfg_we,
  input  logic [msi_pkg::CFG_ADDR_WIDTH-1:0]  cfg_addr,
  input  logic [msi_pkg::DATA_WIDTH-1:0]      cfg_wdata,
  msi_cfg_if.regs                             cfg
);
  import msi_pkg::*;

  logic [NUM_DEST-1:0][ADDR_WIDTH-1:0]       dest_addr_q;
  logic [NUM_IRQ-1:0]                        irq_enable_q;
  logic [NUM_IRQ-1:0][DEST_IDX_WIDTH-1:0]    dest_idx_q;
  logic [NUM_IRQ-1:0][DEVICE_ID_WIDTH-1:0]   device_id_q;
  logic [NUM_IRQ-1:0][EVENT_ID_WIDTH-1:0]    event_id_q;
  logic                                      throttle_en_q;
  logic [THROTTLE_WIDTH-1:0]                 threshold_q;

  // Line number addressed by a REG_IRQn offset
  logic [IRQ_IDX_WIDTH-1:0] irq_sel;

  assign irq_sel = IRQ_IDX_WIDTH'((cfg_addr - CFG_ADDR_WIDTH'(REG_IRQ0)) >> REG_SHIFT);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dest_addr_q   <= '0;
      irq_enable_q  <= '0;
      dest_idx_q    <= '0;
      device_id_q   <= '0;
      event_id_q    <= '0;
      throttle_en_q <= 1'b0;
      threshold_q   <= '0;
    end else if (cfg_we) begin
      case (cfg_addr)
        REG_THROTTLE: begin
          throttle_en_q <= cfg_wdata[THR_EN_BIT];
          threshold_q   <= cfg_wdata[THR_LSB +: THROTTLE_WIDTH];
        end
        REG_DEST0: begin
          dest_addr_q[0] <= cfg_wdata[ADDR_WIDTH-1:0];
        end
        REG_DEST1: begin
          dest_addr_q[1] <= cfg_wdata[ADDR_WIDTH-1:0];
        end
        REG_IRQ0, REG_IRQ1, REG_IRQ2, REG_IRQ3: begin
          event_id_q[irq_sel]   <= cfg_wdata[IRQ_EVENT_LSB +: EVENT_ID_WIDTH];
          device_id_q[irq_sel]  <= cfg_wdata[IRQ_DEVICE_LSB +: DEVICE_ID_WIDTH];
          dest_idx_q[irq_sel]   <= cfg_wdata[IRQ_DEST_LSB +: DEST_IDX_WIDTH];
          irq_enable_q[irq_sel] <= cfg_wdata[IRQ_EN_BIT];
        end
        // Unmapped offsets fall through untouched
        default: begin
        end
      endcase
    end
  end

  assign cfg.dest_addr          = dest_addr_q;
  assign cfg.irq_enable         = irq_enable_q;
  assign cfg.dest_idx           = dest_idx_q;
  assign cfg.device_id          = device_id_q;
  assign cfg.event_id           = event_id_q;
  assign cfg.throttle_en        = throttle_en_q;
  assign cfg.throttle_threshold = threshold_q;

  // Enabled throttle with a zero threshold silently acts as no throttle
  a_throttle_threshold: assert property (
    @(posedge clk) disable iff (rst)
    (cfg_we && cfg_addr == REG_THROTTLE) |=> !(throttle_en_q && threshold_q == '0)
  ) else $warning("throttle enabled with zero threshold");

endmodule

// ==== hw/msi_irq_pending.sv ====
// Interrupt edge capture and arbitration
module msi_irq_pending (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [msi_pkg::NUM_IRQ-1:0]        irq,
  input  logic                               req_grant,
  msi_cfg_if.pending                         cfg,
  output logic                               req_valid,
  output logic [msi_pkg::IRQ_IDX_WIDTH-1:0]  req_irq
);
  import msi_pkg::*;

  logic [NUM_IRQ-1:0]       irq_q;
  logic [NUM_IRQ-1:0]       rise_q;
  logic [NUM_IRQ-1:0]       pending_q;
  logic [NUM_IRQ-1:0]       grant_mask;
  logic [IRQ_IDX_WIDTH-1:0] rr_ptr_q;

  // Edges seen on enabled lines, registered once
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_q  <= '0;
      rise_q <= '0;
    end else begin
      irq_q  <= irq;
      rise_q <= irq & ~irq_q & cfg.irq_enable;
    end
  end

  assign grant_mask = req_grant ? (NUM_IRQ'(1) << req_irq) : '0;

  // An edge landing on the grant cycle merges with the message being sent
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q | rise_q) & ~grant_mask;
    end
  end

  // Pointer moves to one past the granted line
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rr_ptr_q <= '0;
    end else if (req_grant) begin
      if (req_irq == IRQ_IDX_WIDTH'(NUM_IRQ - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= req_irq + 1'b1;
      end
    end
  end

  // Search downward so the nearest pending line at or after the pointer wins
  always_comb begin
    logic [IRQ_IDX_WIDTH-1:0] cand;
    req_irq = rr_ptr_q;
    for (int off = NUM_IRQ - 1; off >= 0; off--) begin
      cand = IRQ_IDX_WIDTH'((int'(rr_ptr_q) + off) % NUM_IRQ);
      if (pending_q[cand]) begin
        req_irq = cand;
      end
    end
  end

  assign req_valid = |pending_q;

  // Writer must only grant while a line is waiting
  a_grant_valid: assert property (
    @(posedge clk) disable iff (rst)
    req_grant |-> req_valid
  );

endmodule

// ==== hw/msi_axil_writer.sv ====
// AXI4-Lite MSI write sequencer
module msi_axil_writer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req_valid,
  input  logic [msi_pkg::IRQ_IDX_WIDTH-1:0]   req_irq,
  msi_cfg_if.writer                           cfg,
  output logic                                req_grant,
  // AW channel
  output logic [msi_pkg::ADDR_WIDTH-1:0]      init_awaddr,
  output logic                                init_awvalid,
  input  logic                                init_awready,
  // W channel
  output logic [msi_pkg::DATA_WIDTH-1:0]      init_wdata,
  output logic [msi_pkg::STRB_WIDTH-1:0]      init_wstrb,
  output logic                                init_wvalid,
  input  logic                                init_wready,
  // B channel
  input  msi_pkg::msi_resp_e                  init_bresp,
  input  logic                                init_bvalid,
  output logic                                init_bready,
  output logic                                error
);
  import msi_pkg::*;

  msi_wr_state_e             state_q;
  logic                      awvalid_q;
  logic                      wvalid_q;
  logic                      error_q;
  logic [ADDR_WIDTH-1:0]     awaddr_q;
  logic [DATA_WIDTH-1:0]     wdata_q;
  logic [ADDR_WIDTH-1:0]     msg_addr;
  logic [DATA_WIDTH-1:0]     msg_data;
  logic [THROTTLE_WIDTH-1:0] throttle_cnt_q;
  logic                      throttle_active;
  logic                      aw_done;
  logic                      w_done;

  // Base of the selected destination plus device id in 32-bit words
  assign msg_addr = cfg.dest_addr[cfg.dest_idx[req_irq]]
                  + {{(ADDR_WIDTH - DEVICE_ID_WIDTH - 2){1'b0}}, cfg.device_id[req_irq], 2'b00};
  assign msg_data = {{(DATA_WIDTH - EVENT_ID_WIDTH){1'b0}}, cfg.event_id[req_irq]};

  assign req_grant = (state_q == IDLE) && req_valid && (throttle_cnt_q == '0);

  // Channel finished once its valid has dropped or is taken this cycle
  assign aw_done = !awvalid_q || init_awready;
  assign w_done  = !wvalid_q || init_wready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= IDLE;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      error_q   <= 1'b0;
    end else begin
      error_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_grant) begin
            state_q   <= SEND;
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
          end
        end
        SEND: begin
          if (awvalid_q && init_awready) begin
            awvalid_q <= 1'b0;
          end
          if (wvalid_q && init_wready) begin
            wvalid_q <= 1'b0;
          end
          if (aw_done && w_done) begin
            state_q <= RESP;
          end
        end
        RESP: begin
          if (init_bvalid) begin
            state_q <= IDLE;
            error_q <= (init_bresp != OKAY);
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Message payload captured at the grant
  always_ff @(posedge clk) begin
    if (req_grant) begin
      awaddr_q <= msg_addr;
      wdata_q  <= msg_data;
    end
  end

  // Zero threshold means no spacing
  assign throttle_active = cfg.throttle_en && (cfg.throttle_threshold != '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      throttle_cnt_q <= '0;
    end else if (req_grant && throttle_active) begin
      throttle_cnt_q <= cfg.throttle_threshold - 1'b1;
    end else if (throttle_cnt_q != '0) begin
      throttle_cnt_q <= throttle_cnt_q - 1'b1;
    end
  end

  assign init_awaddr  = awaddr_q;
  assign init_awvalid = awvalid_q;
  assign init_wdata   = wdata_q;
  assign init_wstrb   = MSG_WSTRB;
  assign init_wvalid  = wvalid_q;
  assign init_bready  = (state_q == RESP);
  assign error        = error_q;

  // Payload held while the target stalls
  a_awaddr_stable: assert property (
    @(posedge clk) disable iff (rst)
    (init_awvalid && !init_awready) |=> $stable(init_awaddr)
  );
  a_wdata_stable: assert property (
    @(posedge clk) disable iff (rst)
    (init_wvalid && !init_wready) |=> $stable(init_wdata)
  );

  // No new message start inside the throttle window
  a_throttle_gap: assert property (
    @(posedge clk) disable iff (rst)
    (throttle_cnt_q != '0) |=> !$rose(init_awvalid)
  );

endmodule

// ==== hw/msi_axil_top.sv ====
// AXI4-Lite MSI generator top
module msi_axil_top (
  input  logic                                clk,
  input  logic                                rst,
  // Configuration write port
  input  logic                                cfg_we,
  input  logic [msi_pkg::CFG_ADDR_WIDTH-1:0]  cfg_addr,
  input  logic [msi_pkg::DATA_WIDTH-1:0]      cfg_wdata,
  // Level interrupt lines
  input  logic [msi_pkg::NUM_IRQ-1:0]         irq,
  // AW channel
  output logic [msi_pkg::ADDR_WIDTH-1:0]      init_awaddr,
  output logic                                init_awvalid,
  input  logic                                init_awready,
  // W channel
  output logic [msi_pkg::DATA_WIDTH-1:0]      init_wdata,
  output logic [msi_pkg::STRB_WIDTH-1:0]      init_wstrb,
  output logic                                init_wvalid,
  input  logic                                init_wready,
  // B channel
  input  msi_pkg::msi_resp_e                  init_bresp,
  input  logic                                init_bvalid,
  output logic                                init_bready,
  output logic                                error
);
  import msi_pkg::*;

  logic                     req_valid;
  logic [IRQ_IDX_WIDTH-1:0] req_irq;
  logic                     req_grant;

  msi_cfg_if cfg_bus ();

  msi_cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg_bus.regs)
  );

  msi_irq_pending u_irq_pending (
    .clk       (clk),
    .rst       (rst),
    .irq       (irq),
    .req_grant (req_grant),
    .cfg       (cfg_bus.pending),
    .req_valid (req_valid),
    .req_irq   (req_irq)
  );

  msi_axil_writer u_writer (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_irq      (req_irq),
    .cfg          (cfg_bus.writer),
    .req_grant    (req_grant),
    .init_awaddr  (init_awaddr),
    .init_awvalid (init_awvalid),
    .init_awready (init_awready),
    .init_wdata   (init_wdata),
    .init_wstrb   (init_wstrb),
    .init_wvalid  (init_wvalid),
    .init_wready  (init_wready),
    .init_bresp   (init_bresp),
    .init_bvalid  (init_bvalid),
    .init_bready  (init_bready),
    .error        (error)
  );

endmodule

// ==== testbench/tb_clock.sv ====
// Testbench clock and reset
module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #2 rst = 1'b0;
  end

endmodule

// ==== testbench/tb_msi.sv ====
// MSI generator testbench
module tb_msi;
  timeunit 1ns;
  timeprecision 100ps;
  import msi_pkg::*;

  logic clk, rst, cfg_we, init_awvalid, init_awready, init_wvalid, init_wready;
  logic init_bvalid, init_bready, error;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [DATA_WIDTH-1:0] cfg_wdata, init_wdata;
  logic [NUM_IRQ-1:0] irq;
  logic [ADDR_WIDTH-1:0] init_awaddr;
  logic [STRB_WIDTH-1:0] init_wstrb;
  msi_resp_e init_bresp;

  tb_clock u_clock (.clk(clk), .rst(rst));

  msi_axil_top DUT (.*);

  logic [15:0] lfsr = 16'd41901;
  int check_errors = 0, protocol_errors = 0, messages = 0, cyc = 0;
  bit timed_out = 0;

  // Reference model state
  logic [NUM_IRQ-1:0] m_irq_q = '0, m_rise_q = '0, m_pend = '0, m_en = '0;
  logic [ADDR_WIDTH-1:0] m_base [NUM_DEST];
  logic [15:0] m_dev [NUM_IRQ], m_ev [NUM_IRQ];
  logic m_dest [NUM_IRQ];
  bit m_thr_en = 0, m_busy = 0, grant_prev = 0, err_exp = 0;
  int m_thr = 0, m_cnt = 0, m_ptr = 0, last_rise = -1;
  int aw_exp [$], w_exp [$];
  int aw_cnt = 0, w_cnt = 0, b_cnt = 0, r_cnt = 0;
  logic prev_awvalid = 0, prev_awready = 0, prev_wvalid = 0, prev_wready = 0;
  logic [ADDR_WIDTH-1:0] prev_awaddr;
  logic [DATA_WIDTH-1:0] prev_wdata;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [63:0] rnd_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  task automatic check_addr(input logic [ADDR_WIDTH-1:0] got, exp, input string what);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s address %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input logic [DATA_WIDTH-1:0] got, exp,
                            input logic [STRB_WIDTH-1:0] strb, input string what);
    if (got !== exp || strb !== 8'h0f) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s data %h strobe %h, expected %h strobe 0f",
               $time, what, got, strb, exp);
    end
  endtask

  task automatic check_resp_error(input msi_resp_e resp, input logic got, exp);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: error %b after response %s, expected %b",
               $time, got, resp.name(), exp);
    end
  endtask

  task automatic protocol_fail(input string msg);
    protocol_errors++;
    $display("Protocol error at %0t: %s", $time, msg);
  endtask

  // Model and monitor evaluated mid-cycle where all signals are settled
  always @(negedge clk) begin
    int sel;
    bit grant;
    bit found;
    bit b_done;
    msi_resp_e last_bresp;
    if (rst) begin
      m_pend = '0;
    end else begin
      cyc++;
      b_done = 0;
      check_resp_error(init_bresp, error, err_exp);
      err_exp = 0;
      // Message start must follow a predicted grant by one cycle
      if (init_awvalid && !prev_awvalid) begin
        if (!grant_prev) protocol_fail("awvalid rose without a pending request");
        if (m_thr_en && m_thr != 0 && last_rise >= 0 && cyc - last_rise < m_thr)
          protocol_fail("message started inside the throttle window");
        last_rise = cyc;
      end else if (grant_prev) begin
        protocol_fail("expected message did not start");
      end
      if (init_awvalid != init_wvalid && !prev_awvalid && !prev_wvalid)
        protocol_fail("awvalid and wvalid did not rise together");
      if (prev_awvalid && !prev_awready) begin
        if (!init_awvalid) protocol_fail("awvalid dropped before awready");
        check_addr(init_awaddr, prev_awaddr, "stalled");
      end
      if (prev_wvalid && !prev_wready) begin
        if (!init_wvalid) protocol_fail("wvalid dropped before wready");
        check_data(init_wdata, prev_wdata, init_wstrb, "stalled");
      end
      if (init_bready && !m_busy) protocol_fail("bready high with no message in flight");
      if (init_awvalid && init_awready) begin
        aw_cnt++;
        if (aw_exp.size() == 0) protocol_fail("unexpected AW transfer");
        else begin
          sel = aw_exp.pop_front();
          check_addr(init_awaddr, m_base[m_dest[sel]] + 4 * ADDR_WIDTH'(m_dev[sel]), "AW");
        end
      end
      if (init_wvalid && init_wready) begin
        w_cnt++;
        if (w_exp.size() == 0) protocol_fail("unexpected W transfer");
        else begin
          sel = w_exp.pop_front();
          check_data(init_wdata, DATA_WIDTH'(m_ev[sel]), init_wstrb, "W");
        end
      end
      if (init_bvalid && init_bready) begin
        b_cnt++;
        messages++;
        b_done = 1;
        last_bresp = init_bresp;
        err_exp = (last_bresp != OKAY);
      end
      // Round-robin selection at or after the pointer
      sel = m_ptr;
      found = 0;
      for (int off = 0; off < NUM_IRQ; off++) begin
        if (!found && m_pend[(m_ptr + off) % NUM_IRQ]) begin
          sel = (m_ptr + off) % NUM_IRQ;
          found = 1;
        end
      end
      grant = !m_busy && (m_pend != '0) && (m_cnt == 0);
      // Writer is back in IDLE on the cycle after the B transfer
      if (b_done) m_busy = 0;
      m_pend = m_pend | m_rise_q;
      m_rise_q = irq & ~m_irq_q & m_en;
      m_irq_q = irq;
      if (grant) begin
        m_pend[sel] = 1'b0;
        m_ptr = (sel + 1) % NUM_IRQ;
        m_busy = 1;
        aw_exp.push_back(sel);
        w_exp.push_back(sel);
      end
      if (grant && m_thr_en && m_thr != 0) m_cnt = m_thr - 1;
      else if (m_cnt != 0) m_cnt--;
      grant_prev = grant;
    end
    prev_awvalid = init_awvalid;
    prev_awready = init_awready;
    prev_wvalid = init_wvalid;
    prev_wready = init_wready;
    prev_awaddr = init_awaddr;
    prev_wdata = init_wdata;
  end

  // AXI responder with random ready and response delays
  initial begin
    int delay;
    delay = 0;
    forever begin
      @(posedge clk);
      #2;
      init_awready = (rnd_bits(2) != 0);
      init_wready = (rnd_bits(2) != 0);
      if (init_bvalid && b_cnt == r_cnt) begin
        init_bvalid = 1'b0;
      end else if (!init_bvalid && aw_cnt > r_cnt && w_cnt > r_cnt) begin
        if (delay == 0) begin
          init_bvalid = 1'b1;
          init_bresp = (rnd_bits(3) == 0) ? SLVERR : OKAY;
          r_cnt++;
          delay = int'(rnd_bits(2));
        end else begin
          delay--;
        end
      end
    end
  end

  task automatic cfg_write(input msi_reg_e addr, input logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    #2;
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(posedge clk);
    #2;
    cfg_we = 1'b0;
  endtask

  task automatic configure();
    msi_reg_e regs [NUM_IRQ] = '{REG_IRQ0, REG_IRQ1, REG_IRQ2, REG_IRQ3};
    m_thr_en = 1'(rnd_bits(1));
    m_thr = int'(rnd_bits(3));
    cfg_write(REG_THROTTLE, {32'b0, 16'(m_thr), 15'b0, m_thr_en});
    for (int d = 0; d < NUM_DEST; d++) begin
      m_base[d] = ADDR_WIDTH'(rnd_bits(ADDR_WIDTH));
      cfg_write(d == 0 ? REG_DEST0 : REG_DEST1, DATA_WIDTH'(m_base[d]));
    end
    for (int i = 0; i < NUM_IRQ; i++) begin
      m_ev[i] = 16'(rnd_bits(16));
      m_dev[i] = 16'(rnd_bits(16));
      m_dest[i] = 1'(rnd_bits(1));
      m_en[i] = 1'(rnd_bits(1));
      cfg_write(regs[i], {m_en[i], 30'b0, m_dest[i], m_dev[i], m_ev[i]});
    end
  endtask

  // Wait until nothing is pending or in flight
  task automatic wait_quiet();
    int n;
    n = 0;
    while (m_pend != '0 || m_rise_q != '0 || m_busy || m_cnt != 0 || init_bvalid) begin
      @(posedge clk);
      n++;
      if (n > 2000) begin
        timed_out = 1;
        $display("Timeout: design did not drain its pending messages");
        return;
      end
    end
  endtask

  initial begin
    int n;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    irq = '0;
    init_awready = 1'b0;
    init_wready = 1'b0;
    init_bvalid = 1'b0;
    init_bresp = OKAY;
    n = 0;
    while (rst !== 1'b0 && !timed_out) begin
      @(posedge clk);
      n++;
      if (n > 20) begin
        timed_out = 1;
        $display("Timeout: reset was never released");
      end
    end
    for (int phase = 0; phase < 4 && !timed_out; phase++) begin
      wait_quiet();
      if (!timed_out) configure();
      for (int c = 0; c < 300 && !timed_out; c++) begin
        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_IRQ; i++)
          if (rnd_bits(2) == 0) irq[i] = ~irq[i];
      end
      irq = '0;
    end
    if (!timed_out) wait_quiet();
    repeat (5) @(posedge clk);
    if (messages == 0) protocol_fail("no message was produced");
    $display("Messages %0d, check errors %0d, protocol errors %0d, timeouts %0d",
             messages, check_errors, protocol_errors, int'(timed_out));
    if (check_errors == 0 && protocol_errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/msi_pkg.sv
hw/msi_cfg_if.sv
hw/msi_cfg_regs.sv
hw/msi_irq_pending.sv
hw/msi_axil_writer.sv
hw/msi_axil_top.sv
testbench/tb_clock.sv
testbench/tb_msi.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; pass only if the pass message is printed
verilator --binary --timing --assert --top-module tb_msi -f sources.f -o tb_msi_sim \
  && ./obj_dir/tb_msi_sim | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
